/* frogger_settings.svh */
`ifndef FROGGER_SETTINGS_SVH
`define FROGGER_SETTINGS_SVH

// --------------------------------------------------
// Playfield geometry
// --------------------------------------------------
`define SCREEN_W        640     // x wraps modulo this
`define OBJ_W           60      // Car and pad width
`define FROG_W          20
`define STEP_Y          40      // One row
`define STEP_X          20
`define START_Y         440     // Bottom row, frogs spawn here
`define HOME_Y          40      // Reaching this row wins
`define FROG1_X         120
`define FROG2_X         320
`define FROG3_X         520

// --------------------------------------------------
// Lanes
// --------------------------------------------------
`define CAR_Y0          400
`define CAR_Y1          360
`define CAR_Y2          320
`define CAR_Y3          280
`define PAD_Y0          200
`define PAD_Y1          160
`define PAD_Y2          120
`define PAD_Y3          80
`define CAR_SPEED0      10
`define CAR_SPEED1      7
`define CAR_SPEED2      3
`define CAR_SPEED3      1
`define PAD_SPEED0      30
`define PAD_SPEED1      27
`define PAD_SPEED2      30
`define PAD_SPEED3      25
`define LANE_GAP        80      // Space between neighbouring objects

// --------------------------------------------------
// Game timer, lives and keycodes
// --------------------------------------------------
`define FRAMES_PER_SEC  4       // Kept short for simulation
`define START_TIME      20
`define START_LIVES     3
`define KEY_LEFT        16'h0050
`define KEY_RIGHT       16'h004F
`define KEY_UP          16'h0052
`define KEY_DOWN        16'h0051
`define KEY_FROG1       16'h0059
`define KEY_FROG2       16'h005A
`define KEY_FROG3       16'h005B

`endif

/* frogger_pkg.sv */
package frogger_pkg;

    // Screen coordinate, wide enough for the 640 pixel playfield
    typedef logic [10:0] coord_t;

    // x positions of the four objects in one lane
    typedef coord_t [3:0] lane_x_t;

    // 0 means no frog selected, 1 to 3 name a frog
    typedef logic [1:0] frog_sel_t;

endpackage

/* key_decoder.sv */
`timescale 1ns/1ps
`include "frogger_settings.svh"

module key_decoder (
    input  logic                   Clk,
    input  logic                   reset,
    input  logic [15:0]            keycode,
    output logic                   move_up,
    output logic                   move_down,
    output logic                   move_left,
    output logic                   move_right,
    output frogger_pkg::frog_sel_t active_frog
);

    logic [15:0] key_prev;
    logic        key_new;

    assign key_new = (keycode != key_prev);  // Edge on any code change

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            key_prev    <= '0;
            move_up     <= 1'b0;
            move_down   <= 1'b0;
            move_left   <= 1'b0;
            move_right  <= 1'b0;
            active_frog <= 2'd0;
        end
        else
        begin
            key_prev   <= keycode;
            move_up    <= key_new && (keycode == `KEY_UP);
            move_down  <= key_new && (keycode == `KEY_DOWN);
            move_left  <= key_new && (keycode == `KEY_LEFT);
            move_right <= key_new && (keycode == `KEY_RIGHT);

            // Selection sticks until another frog key
            if (keycode == `KEY_FROG1)
                active_frog <= 2'd1;
            else if (keycode == `KEY_FROG2)
                active_frog <= 2'd2;
            else if (keycode == `KEY_FROG3)
                active_frog <= 2'd3;
        end
    end

endmodule

/* lane_row.sv */
`timescale 1ns/1ps
`include "frogger_settings.svh"

module lane_row #(
    parameter int LANE_Y = `CAR_Y0,
    parameter int SPEED  = `CAR_SPEED0,
    parameter bit DIR    = 1'b1         // 1 moves right
) (
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 frame_tick,
    input  logic                 freeze,
    input  frogger_pkg::coord_t  frog_x,
    input  frogger_pkg::coord_t  frog_y,
    output frogger_pkg::lane_x_t obj_x,
    output logic                 hit
);

    localparam frogger_pkg::coord_t SPEED_C = frogger_pkg::coord_t'(SPEED);
    localparam frogger_pkg::coord_t WRAP_C  = frogger_pkg::coord_t'(`SCREEN_W);
    localparam int                  PITCH   = `OBJ_W + `LANE_GAP;

    frogger_pkg::lane_x_t step_x;

    // --------------------------------------------------
    // Next positions, wrapping at the screen edge
    // --------------------------------------------------
    always_comb
    begin
        for (int k = 0; k < 4; k++)
        begin
            if (DIR)
                step_x[k] = (obj_x[k] + SPEED_C >= WRAP_C) ? obj_x[k] + SPEED_C - WRAP_C
                                                           : obj_x[k] + SPEED_C;
            else
                step_x[k] = (obj_x[k] < SPEED_C) ? obj_x[k] + WRAP_C - SPEED_C
                                                 : obj_x[k] - SPEED_C;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            for (int k = 0; k < 4; k++)
                obj_x[k] <= frogger_pkg::coord_t'(k * PITCH);  // Evenly spaced start
        end
        else if (frame_tick && !freeze)
        begin
            obj_x <= step_x;
        end
    end

    // --------------------------------------------------
    // Overlap with the active frog on this row
    // --------------------------------------------------
    always_comb
    begin
        hit = 1'b0;
        if (frog_y == LANE_Y)
        begin
            for (int k = 0; k < 4; k++)
            begin
                // Wrap at the edge is not considered
                if ((frog_x < obj_x[k] + `OBJ_W) && (frog_x + `FROG_W > obj_x[k]))
                    hit = 1'b1;
            end
        end
    end

endmodule

/* frog_unit.sv */
`timescale 1ns/1ps
`include "frogger_settings.svh"

module frog_unit #(
    parameter int START_X = `FROG1_X
) (
    input  logic                Clk,
    input  logic                reset,
    input  logic                frame_tick,
    input  logic                freeze,
    input  logic                selected,
    input  logic                move_up,
    input  logic                move_down,
    input  logic                move_left,
    input  logic                move_right,
    input  logic [3:0]          car_hit,
    input  logic [3:0]          pad_hit,
    output frogger_pkg::coord_t frog_x,
    output frogger_pkg::coord_t frog_y,
    output logic                dead
);

    localparam frogger_pkg::coord_t START_X_C = frogger_pkg::coord_t'(START_X);
    localparam frogger_pkg::coord_t START_Y_C = frogger_pkg::coord_t'(`START_Y);
    localparam frogger_pkg::coord_t HOME_Y_C  = frogger_pkg::coord_t'(`HOME_Y);
    localparam frogger_pkg::coord_t STEP_X_C  = frogger_pkg::coord_t'(`STEP_X);
    localparam frogger_pkg::coord_t STEP_Y_C  = frogger_pkg::coord_t'(`STEP_Y);
    localparam frogger_pkg::coord_t MAX_X_C   = frogger_pkg::coord_t'(`SCREEN_W - `FROG_W);

    logic                pend_up, pend_down, pend_left, pend_right;
    logic                on_car_row, on_pad_row, dies;
    logic                ride_dir;
    logic [5:0]          ride_speed;
    frogger_pkg::coord_t ride_x, next_x, next_y;

    // --------------------------------------------------
    // Row lookup and hazard check
    // --------------------------------------------------
    always_comb
    begin
        on_car_row = (frog_y == `CAR_Y0) || (frog_y == `CAR_Y1) ||
                     (frog_y == `CAR_Y2) || (frog_y == `CAR_Y3);
        on_pad_row = 1'b1;
        ride_dir   = 1'b0;
        ride_speed = '0;
        case (frog_y)
            `PAD_Y0:
            begin
                ride_speed = 6'(`PAD_SPEED0);
                ride_dir   = 1'b1;
            end
            `PAD_Y1: ride_speed = 6'(`PAD_SPEED1);
            `PAD_Y2:
            begin
                ride_speed = 6'(`PAD_SPEED2);
                ride_dir   = 1'b1;
            end
            `PAD_Y3: ride_speed = 6'(`PAD_SPEED3);
            default: on_pad_row = 1'b0;
        endcase

        // Open water when no pad lies under the frog
        dies = (on_car_row && (|car_hit)) || (on_pad_row && !(|pad_hit));
    end

    // --------------------------------------------------
    // Riding, then the pending move
    // --------------------------------------------------
    always_comb
    begin
        if (!on_pad_row)
            ride_x = frog_x;
        else if (ride_dir)
            ride_x = (frog_x + ride_speed > MAX_X_C) ? MAX_X_C : frog_x + ride_speed;
        else
            ride_x = (frog_x < ride_speed) ? '0 : frog_x - ride_speed;

        next_x = ride_x;
        next_y = frog_y;
        if (pend_up && (frog_y > HOME_Y_C))
            next_y = frog_y - STEP_Y_C;
        else if (pend_down && (frog_y < START_Y_C))
            next_y = frog_y + STEP_Y_C;
        else if (pend_left)
            next_x = (ride_x < STEP_X_C) ? '0 : ride_x - STEP_X_C;
        else if (pend_right)
            next_x = (ride_x + STEP_X_C > MAX_X_C) ? MAX_X_C : ride_x + STEP_X_C;
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            frog_x     <= START_X_C;
            frog_y     <= START_Y_C;
            dead       <= 1'b0;
            pend_up    <= 1'b0;
            pend_down  <= 1'b0;
            pend_left  <= 1'b0;
            pend_right <= 1'b0;
        end
        else
        begin
            dead <= 1'b0;
            if (frame_tick)
            begin
                {pend_up, pend_down, pend_left, pend_right} <= 4'b0;  // Consumed
                if (selected && !freeze)
                begin
                    if (dies)
                    begin
                        frog_x <= START_X_C;  // Respawn
                        frog_y <= START_Y_C;
                        dead   <= 1'b1;
                    end
                    else
                    begin
                        frog_x <= next_x;
                        frog_y <= next_y;
                    end
                end
            end
            // A newer arrow overwrites the pending one
            if (selected && (move_up || move_down || move_left || move_right))
            begin
                pend_up    <= move_up;
                pend_down  <= move_down;
                pend_left  <= move_left;
                pend_right <= move_right;
            end
        end
    end

endmodule

/* game_control.sv */
`timescale 1ns/1ps
`include "frogger_settings.svh"

module game_control (
    input  logic                Clk,
    input  logic                reset,
    input  logic                frame_tick,
    input  logic                dead,
    input  frogger_pkg::coord_t frog1_y,
    input  frogger_pkg::coord_t frog2_y,
    input  frogger_pkg::coord_t frog3_y,
    output logic [7:0]          frog_lives,
    output logic [3:0]          tens_digit,
    output logic [3:0]          ones_digit,
    output logic                win_game,
    output logic                lose_game
);

    logic [7:0] clock_time;
    logic [2:0] frame_cnt;
    logic       frozen;

    assign frozen = win_game || lose_game;

    assign tens_digit = 4'(clock_time / 8'd10);
    assign ones_digit = 4'(clock_time % 8'd10);

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            clock_time <= 8'(`START_TIME);
            frame_cnt  <= '0;
            frog_lives <= 8'(`START_LIVES);
            win_game   <= 1'b0;
            lose_game  <= 1'b0;
        end
        else
        begin
            // Frames into seconds
            if (frame_tick && !frozen)
            begin
                if (frame_cnt == 3'(`FRAMES_PER_SEC - 1))
                begin
                    frame_cnt <= '0;
                    if (clock_time != 8'd0)
                        clock_time <= clock_time - 8'd1;
                end
                else
                begin
                    frame_cnt <= frame_cnt + 3'd1;
                end
            end

            if (dead && (frog_lives != 8'd0))
                frog_lives <= frog_lives - 8'd1;

            // Flags are sticky, first one wins
            if (!lose_game && ((frog1_y == `HOME_Y) || (frog2_y == `HOME_Y) ||
                               (frog3_y == `HOME_Y)))
                win_game <= 1'b1;
            if (!win_game && ((clock_time == 8'd0) || (frog_lives == 8'd0)))
                lose_game <= 1'b1;
        end
    end

endmodule

/* frogger_core.sv */
`timescale 1ns/1ps
`include "frogger_settings.svh"

module frogger_core (
    input  logic                Clk,
    input  logic                reset,
    input  logic [15:0]         keycode,
    input  logic                frame_tick,
    output frogger_pkg::coord_t frog1_x,
    output frogger_pkg::coord_t frog1_y,
    output frogger_pkg::coord_t frog2_x,
    output frogger_pkg::coord_t frog2_y,
    output frogger_pkg::coord_t frog3_x,
    output frogger_pkg::coord_t frog3_y,
    output logic [7:0]          frog_lives,
    output logic [3:0]          tens_digit,
    output logic [3:0]          ones_digit,
    output logic                win_game,
    output logic                lose_game,
    output logic [3:0]          car_hit,
    output logic [3:0]          pad_hit
);

    localparam int CAR_Y [4]     = '{`CAR_Y0, `CAR_Y1, `CAR_Y2, `CAR_Y3};
    localparam int CAR_SPEED [4] = '{`CAR_SPEED0, `CAR_SPEED1, `CAR_SPEED2, `CAR_SPEED3};
    localparam int PAD_Y [4]     = '{`PAD_Y0, `PAD_Y1, `PAD_Y2, `PAD_Y3};
    localparam int PAD_SPEED [4] = '{`PAD_SPEED0, `PAD_SPEED1, `PAD_SPEED2, `PAD_SPEED3};
    localparam int FROG_X [3]    = '{`FROG1_X, `FROG2_X, `FROG3_X};

    logic                   move_up, move_down, move_left, move_right;
    logic                   freeze;
    logic [2:0]             dead_all;
    frogger_pkg::frog_sel_t active_frog;
    frogger_pkg::coord_t    act_x, act_y;
    frogger_pkg::coord_t    frog_x_all [3];
    frogger_pkg::coord_t    frog_y_all [3];

    assign freeze = win_game || lose_game;

    key_decoder u_keys (
        .Clk,
        .reset,
        .keycode,
        .move_up,
        .move_down,
        .move_left,
        .move_right,
        .active_frog
    );

    // --------------------------------------------------
    // Active frog position, seen by every lane
    // --------------------------------------------------
    always_comb
    begin
        act_x = '0;
        act_y = '0;
        if (active_frog != 2'd0)
        begin
            act_x = frog_x_all[active_frog - 2'd1];
            act_y = frog_y_all[active_frog - 2'd1];
        end
    end

    // Even lanes move right, odd lanes left
    for (genvar i = 0; i < 4; i++)
    begin : g_lane
        lane_row #(.LANE_Y(CAR_Y[i]), .SPEED(CAR_SPEED[i]), .DIR(i % 2 == 0)) u_car (
            .Clk, .reset, .frame_tick, .freeze,
            .frog_x(act_x), .frog_y(act_y), .obj_x(), .hit(car_hit[i])
        );
        lane_row #(.LANE_Y(PAD_Y[i]), .SPEED(PAD_SPEED[i]), .DIR(i % 2 == 0)) u_pad (
            .Clk, .reset, .frame_tick, .freeze,
            .frog_x(act_x), .frog_y(act_y), .obj_x(), .hit(pad_hit[i])
        );
    end

    for (genvar f = 0; f < 3; f++)
    begin : g_frog
        frog_unit #(.START_X(FROG_X[f])) u_frog (
            .Clk, .reset, .frame_tick, .freeze,
            .selected(active_frog == 2'(f + 1)),
            .move_up, .move_down, .move_left, .move_right,
            .car_hit, .pad_hit,
            .frog_x(frog_x_all[f]), .frog_y(frog_y_all[f]), .dead(dead_all[f])
        );
    end

    assign frog1_x = frog_x_all[0];
    assign frog1_y = frog_y_all[0];
    assign frog2_x = frog_x_all[1];
    assign frog2_y = frog_y_all[1];
    assign frog3_x = frog_x_all[2];
    assign frog3_y = frog_y_all[2];

    game_control u_ctrl (
        .Clk,
        .reset,
        .frame_tick,
        .dead(|dead_all),
        .frog1_y(frog_y_all[0]),
        .frog2_y(frog_y_all[1]),
        .frog3_y(frog_y_all[2]),
        .frog_lives,
        .tens_digit,
        .ones_digit,
        .win_game,
        .lose_game
    );

endmodule

/* frogger_checker.sv */
`timescale 1ns/1ps

module frogger_checker (
    input logic       Clk,
    input logic       reset,
    input logic       move_up,
    input logic       move_down,
    input logic       move_left,
    input logic       move_right,
    input logic       win_game,
    input logic       lose_game,
    input logic [7:0] frog_lives
);

    int         fail_count = 0;  // Failed assertion attempts
    logic [3:0] moves;

    assign moves = {move_up, move_down, move_left, move_right};

    // --------------------------------------------------
    // Key decoder pulses
    // --------------------------------------------------
    a_move_onehot : assert property (@(posedge Clk) disable iff (reset) $onehot0(moves))
    else
    begin
        $error("Move pulses not one-hot: %b", moves);
        fail_count++;
    end

    a_move_single : assert property (@(posedge Clk) disable iff (reset) (|moves) |=> !(|moves))
    else
    begin
        $error("Move pulse held longer than one cycle");
        fail_count++;
    end

    // --------------------------------------------------
    // Sticky flags and lives
    // --------------------------------------------------
    a_win_hold : assert property (@(posedge Clk) disable iff (reset) win_game |=> win_game)
    else
    begin
        $error("win_game fell without reset");
        fail_count++;
    end

    a_lose_hold : assert property (@(posedge Clk) disable iff (reset) lose_game |=> lose_game)
    else
    begin
        $error("lose_game fell without reset");
        fail_count++;
    end

    a_lives_fall : assert property (@(posedge Clk) disable iff (reset)
                                    !$past(reset) |-> (frog_lives <= $past(frog_lives)))
    else
    begin
        $error("Lives rose from %0d to %0d", $past(frog_lives), frog_lives);
        fail_count++;
    end

endmodule

/* frogger_tb.sv */
`timescale 1ns/1ps
`include "frogger_settings.svh"

module frogger_tb;

    localparam int MAX_ROWS     = 400;
    localparam int MAX_X        = `SCREEN_W - `FROG_W;
    localparam int LANE_Y [8]   = '{`CAR_Y0, `CAR_Y1, `CAR_Y2, `CAR_Y3,
                                    `PAD_Y0, `PAD_Y1, `PAD_Y2, `PAD_Y3};
    localparam int LANE_SPD [8] = '{`CAR_SPEED0, `CAR_SPEED1, `CAR_SPEED2, `CAR_SPEED3,
                                    `PAD_SPEED0, `PAD_SPEED1, `PAD_SPEED2, `PAD_SPEED3};
    localparam int START_X [3]  = '{`FROG1_X, `FROG2_X, `FROG3_X};

    // One stimulus row and the state expected after it
    typedef struct {
        int key;
        int frames;
        bit rst;
        int f1x, f1y, f2x, f2y, f3x, f3y;
        int lives, tens, ones;
        int win, lose, car, pad;
    } row_t;

    logic                Clk = 1'b0;
    logic                reset;
    logic [15:0]         keycode;
    logic                frame_tick;
    frogger_pkg::coord_t frog1_x, frog1_y, frog2_x, frog2_y, frog3_x, frog3_y;
    logic [7:0]          frog_lives;
    logic [3:0]          tens_digit, ones_digit, car_hit, pad_hit;
    logic                win_game, lose_game;

    row_t        rows [MAX_ROWS];
    int          n_rows = 0;
    int          errors = 0;
    int          cur_row = 0;
    longint      run_cycles = 0;
    bit          table_ready = 1'b0;
    logic [31:0] lfsr = 32'd78965;

    // --------------------------------------------------
    // Reference model state
    // --------------------------------------------------
    int lx [8][4];  // Cars 0 to 3, pads 4 to 7
    int fx [3];
    int fy [3];
    int pend [3];   // Pending arrow per frog
    int sel, lives, tsec, fcnt;
    bit win, lose, dead;

    frogger_core uut (.*);

    bind frogger_core frogger_checker u_checker (
        .Clk(Clk), .reset(reset), .move_up(move_up), .move_down(move_down),
        .move_left(move_left), .move_right(move_right), .win_game(win_game),
        .lose_game(lose_game), .frog_lives(frog_lives)
    );

    always #20 Clk = ~Clk;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int lateral_key();
        lfsr = lfsr_next(lfsr);  // One bit per pick
        return lfsr[0] ? `KEY_RIGHT : `KEY_LEFT;
    endfunction

    function automatic int stepped(int l, int p);
        if (l % 2 == 0)
            return (p + LANE_SPD[l]) % `SCREEN_W;  // Rightward lane
        return (p + `SCREEN_W - LANE_SPD[l]) % `SCREEN_W;
    endfunction

    function automatic bit lane_hit(int l, int x, int y, bit ahead);
        int p;
        bit hit;
        hit = 1'b0;
        for (int k = 0; k < 4; k++)
        begin
            p = ahead ? stepped(l, lx[l][k]) : lx[l][k];
            if (y == LANE_Y[l] && x < p + `OBJ_W && x + `FROG_W > p)
                hit = 1'b1;
        end
        return hit;
    endfunction

    // Survives the hazard check on row y, lanes now or one frame on
    function automatic bit row_safe(int x, int y, bit ahead);
        bit car_any;
        bit pad_any;
        bit pad_row;
        car_any = 1'b0;
        pad_any = 1'b0;
        pad_row = 1'b0;
        for (int l = 0; l < 8; l++)
        begin
            if (l < 4)
                car_any |= lane_hit(l, x, y, ahead);
            else
            begin
                pad_any |= lane_hit(l, x, y, ahead);
                pad_row |= (y == LANE_Y[l]);
            end
        end
        return !car_any && !(pad_row && !pad_any);
    endfunction

    function automatic int ride(int x, int y);
        int r;
        r = x;
        for (int l = 4; l < 8; l++)
        begin
            if (y == LANE_Y[l] && l % 2 == 0)
                r = (x + LANE_SPD[l] > MAX_X) ? MAX_X : x + LANE_SPD[l];
            else if (y == LANE_Y[l])
                r = (x < LANE_SPD[l]) ? 0 : x - LANE_SPD[l];
        end
        return r;
    endfunction

    task automatic model_reset();
        for (int l = 0; l < 8; l++)
            for (int k = 0; k < 4; k++)
                lx[l][k] = k * (`OBJ_W + `LANE_GAP);
        for (int f = 0; f < 3; f++)
        begin
            fx[f] = START_X[f];
            fy[f] = `START_Y;
            pend[f] = 0;
        end
        sel = 0;
        lives = `START_LIVES;
        tsec = `START_TIME;
        fcnt = 0;
        win = 1'b0;
        lose = 1'b0;
    endtask

    task automatic settle_flags();
        bit home;
        bit nwin;
        home = (fy[0] == `HOME_Y) || (fy[1] == `HOME_Y) || (fy[2] == `HOME_Y);
        nwin = win || (!lose && home);
        lose = lose || (!win && (tsec == 0 || lives == 0));
        win = nwin;
    endtask

    task automatic model_frame();
        int f;
        int x;
        int y;
        bit frozen;
        frozen = win || lose;
        dead = 1'b0;
        if (sel != 0 && !frozen)
        begin
            f = sel - 1;
            if (!row_safe(fx[f], fy[f], 1'b0))
            begin
                fx[f] = START_X[f];  // Respawn
                fy[f] = `START_Y;
                dead = 1'b1;
            end
            else
            begin
                x = ride(fx[f], fy[f]);
                y = fy[f];
                case (pend[f])
                    `KEY_UP:    y = (y > `HOME_Y) ? y - `STEP_Y : y;
                    `KEY_DOWN:  y = (y < `START_Y) ? y + `STEP_Y : y;
                    `KEY_LEFT:  x = (x < `STEP_X) ? 0 : x - `STEP_X;
                    `KEY_RIGHT: x = (x + `STEP_X > MAX_X) ? MAX_X : x + `STEP_X;
                    default:    ;
                endcase
                fx[f] = x;
                fy[f] = y;
            end
        end
        for (int i = 0; i < 3; i++)
            pend[i] = 0;
        if (!frozen)
        begin
            for (int l = 0; l < 8; l++)
                for (int k = 0; k < 4; k++)
                    lx[l][k] = stepped(l, lx[l][k]);
            fcnt++;
            if (fcnt == `FRAMES_PER_SEC)
            begin
                fcnt = 0;
                if (tsec > 0)
                    tsec--;
            end
        end
        settle_flags();  // Flags see lives before the decrement
        if (dead && lives > 0)
            lives--;
        settle_flags();
    endtask

    task automatic add_row(int key, int frames, bit rst);
        row_t r;
        int ax;
        int ay;
        if (n_rows >= MAX_ROWS)
            return;
        if (rst)
            model_reset();
        if (key == `KEY_FROG1)
            sel = 1;
        else if (key == `KEY_FROG2)
            sel = 2;
        else if (key == `KEY_FROG3)
            sel = 3;
        else if ((key == `KEY_UP || key == `KEY_DOWN || key == `KEY_LEFT ||
                  key == `KEY_RIGHT) && sel != 0)
            pend[sel - 1] = key;
        repeat (frames)
            model_frame();
        ax = (sel != 0) ? fx[sel - 1] : 0;
        ay = (sel != 0) ? fy[sel - 1] : 0;
        r.key = key;
        r.frames = frames;
        r.rst = rst;
        r.f1x = fx[0];
        r.f1y = fy[0];
        r.f2x = fx[1];
        r.f2y = fy[1];
        r.f3x = fx[2];
        r.f3y = fy[2];
        r.lives = lives;
        r.tens = tsec / 10;
        r.ones = tsec % 10;
        r.win = win;
        r.lose = lose;
        r.car = 0;
        r.pad = 0;
        for (int l = 0; l < 4; l++)
        begin
            r.car |= int'(lane_hit(l, ax, ay, 1'b0)) << l;
            r.pad |= int'(lane_hit(l + 4, ax, ay, 1'b0)) << l;
        end
        rows[n_rows] = r;
        n_rows++;
        run_cycles += (rst ? 4 : 0) + 2 + 4 * frames;
    endtask

    // Either hops up or waits one frame, aiming for or away from a hit
    task automatic plan_step(int f, bit want_death);
        int x;
        bit up_dies;
        bit wait_ok;
        x = ride(fx[f], fy[f]);
        up_dies = !row_safe(x, fy[f] - `STEP_Y, 1'b1);
        wait_ok = row_safe(x, fy[f], 1'b1);
        if (want_death ? up_dies : (!up_dies || !wait_ok))
            add_row(`KEY_UP, 1, 1'b0);
        else
            add_row(0, 1, 1'b0);
    endtask

    task automatic build_table();
        int target;
        // --------------------------------------------------
        // Game 1, selection, countdown, a car death, a win
        // --------------------------------------------------
        add_row(0, 0, 1'b1);
        add_row(`KEY_UP, 1, 1'b0);   // No frog selected
        add_row(16'h0004, 0, 1'b0);
        add_row(`KEY_FROG1, 0, 1'b0);
        add_row(`KEY_UP, 1, 1'b0);
        add_row(16'h0004, 0, 1'b0);  // Selection must survive
        add_row(`KEY_DOWN, 1, 1'b0);
        for (int i = 0; i < 3; i++)
            add_row(0, `FRAMES_PER_SEC, 1'b0);
        for (int i = 0; i < 4; i++)
            add_row(lateral_key(), 1, 1'b0);
        target = lives - 1;
        while (lives > target && !lose && n_rows < MAX_ROWS - 100)
            plan_step(0, 1'b1);
        add_row(`KEY_FROG2, 0, 1'b0);
        while (!win && !lose && n_rows < MAX_ROWS - 100)
            plan_step(1, 1'b0);
        add_row(lateral_key(), 4, 1'b0);  // Frozen by now
        // Game 2, pad death then car deaths until lives run out
        add_row(0, 0, 1'b1);
        add_row(`KEY_FROG1, 0, 1'b0);
        while (fy[0] > `PAD_Y0 + `STEP_Y && !lose && n_rows < MAX_ROWS - 60)
            plan_step(0, 1'b0);
        while (!lose && n_rows < MAX_ROWS - 60)
            plan_step(0, 1'b1);
        add_row(`KEY_UP, 4, 1'b0);
        // Game 3, time runs out
        add_row(0, 0, 1'b1);
        while (!lose && n_rows < MAX_ROWS - 2)
            add_row(0, `FRAMES_PER_SEC, 1'b0);
        add_row(0, `FRAMES_PER_SEC, 1'b0);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at row %0d", name, got, exp, cur_row);
        end
    endtask

    task automatic apply_row(int r);
        if (rows[r].rst)
        begin
            reset = 1'b1;
            repeat (4) @(negedge Clk);
            reset = 1'b0;
        end
        keycode = 16'(rows[r].key);
        repeat (2) @(negedge Clk);  // Pulse, then pending latch
        keycode = '0;
        repeat (rows[r].frames)
        begin
            frame_tick = 1'b1;
            @(negedge Clk);
            frame_tick = 1'b0;
            repeat (3) @(negedge Clk);
        end
        check_value("frog1_x", frog1_x, rows[r].f1x);
        check_value("frog1_y", frog1_y, rows[r].f1y);
        check_value("frog2_x", frog2_x, rows[r].f2x);
        check_value("frog2_y", frog2_y, rows[r].f2y);
        check_value("frog3_x", frog3_x, rows[r].f3x);
        check_value("frog3_y", frog3_y, rows[r].f3y);
        check_value("frog_lives", frog_lives, rows[r].lives);
        check_value("tens_digit", tens_digit, rows[r].tens);
        check_value("ones_digit", ones_digit, rows[r].ones);
        check_value("win_game", win_game, rows[r].win);
        check_value("lose_game", lose_game, rows[r].lose);
        check_value("car_hit", car_hit, rows[r].car);
        check_value("pad_hit", pad_hit, rows[r].pad);
    endtask

    initial
    begin
        reset = 1'b1;
        keycode = '0;
        frame_tick = 1'b0;
        build_table();
        table_ready = 1'b1;
        for (cur_row = 0; cur_row < n_rows; cur_row++)
            apply_row(cur_row);
        errors += uut.u_checker.fail_count;
        $display("Rows applied %0d, errors %0d, assertion failures %0d",
                 n_rows, errors, uut.u_checker.fail_count);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog sized from the table
    initial
    begin
        wait (table_ready);
        #((run_cycles + 100) * 40);
        $display("Watchdog expired before the stimulus table was done");
        $display("Errors found");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
frogger_pkg.sv
key_decoder.sv
lane_row.sv
frog_unit.sv
game_control.sv
frogger_core.sv
frogger_checker.sv
frogger_tb.sv
